// ==== include/rom_system_settings.svh ====
// Reduced memory map, bus widths and read latency for the ROM loading core
`ifndef ROM_SYSTEM_SETTINGS_SVH
`define ROM_SYSTEM_SETTINGS_SVH

// ##########################################################################
// Memory sizes
// ##########################################################################

// Graphics store depth in 32-bit dwords, as log2
`define GFX_WORDS_LOG2 12

// Depth of one program bank in 16-bit words, as log2
`define PROG_WORDS_LOG2 11

// rom0 to rom3 plus the slap bank
`define NUM_PROG_BANKS 5

// Host byte address width
`define LOAD_ADDR_W 16

// ##########################################################################
// Image layout as seen by the host stream
// ##########################################################################

// Graphics area at the start of the image, dword interleaved
`define GFX_BASE 16'h0000
`define GFX_LIMIT 16'h3FFF

// Program banks follow back to back, word interleaved
// Order is rom0, rom1, rom2, rom3, slap
`define PROG_BASE 16'h4000
`define PROG_BANK_BYTES 16'h1000

// Cycles from fetch_req to fetch_valid
`define FETCH_LATENCY 2

`endif

// ==== source/rom_system_pkg.sv ====
// Package with the vector types, the program bank enum and the loader state enum
`include "rom_system_settings.svh"

package rom_system_pkg;

	// Host side
	typedef logic [`LOAD_ADDR_W-1:0] load_addr_t;
	typedef logic [7:0] byte_t;

	// Memory payloads
	typedef logic [15:0] word_t;
	typedef logic [31:0] dword_t;

	// Memory addresses
	typedef logic [`GFX_WORDS_LOG2-1:0] gfx_addr_t;
	typedef logic [`PROG_WORDS_LOG2-1:0] prog_addr_t;

	// One active-low select per program bank, bit 0 is rom0
	typedef logic [`NUM_PROG_BANKS-1:0] bank_sel_t;

	// Target of a program word write
	// Encoding matches the bank index in the image
	typedef enum logic [2:0] {
		bank_rom0 = 3'd0,
		bank_rom1 = 3'd1,
		bank_rom2 = 3'd2,
		bank_rom3 = 3'd3,
		bank_slap = 3'd4,
		bank_none = 3'd5
	} bank_e;

	// Loader phase, tracks the host download flag
	typedef enum logic {
		load_idle,
		load_active
	} load_state_e;

	// Toggle in bit 10, pressed in bit 9, scancode in bits 8:0
	typedef logic [10:0] key_event_t;

	// Active-low system switches
	typedef logic [8:0] sys_sw_t;

endpackage

// ==== source/load_ifs.sv ====
// Interfaces rom_wr_if and gfx_wr_if between the loader and the memories
`timescale 1ns/1ps

// ##########################################################################
// Program word write port
// ##########################################################################

interface rom_wr_if
	import rom_system_pkg::*;
();
	// One-cycle strobe, aligned with the odd byte of a pair
	logic we;
	bank_e bank;
	prog_addr_t addr;
	word_t data;

	modport loader (output we, bank, addr, data);
	modport banks (input we, bank, addr, data);
endinterface

// ##########################################################################
// Graphics dword write port
// ##########################################################################

interface gfx_wr_if
	import rom_system_pkg::*;
();
	// Download in progress, the store belongs to the loader
	logic busy;
	// One-cycle strobe, one cycle after the last byte of a dword
	logic we;
	gfx_addr_t addr;
	dword_t data;

	modport loader (output busy, we, addr, data);
	modport store (input busy, we, addr, data);
endinterface

// ==== source/rom_loader.sv ====
// Host byte accumulator, image region decoder and program and graphics write strobes
`timescale 1ns/1ps
`include "rom_system_settings.svh"

module rom_loader
	import rom_system_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       download,
	input  logic       load_wr,
	input  load_addr_t load_addr,
	input  byte_t      load_data,
	rom_wr_if.loader   prog_wr,
	gfx_wr_if.loader   gfx_wr
);

	// Three most recent bytes, oldest in the top byte
	logic [23:0] acc_bytes;
	load_state_e state;

	// Region decode
	load_addr_t gfx_off;
	load_addr_t prog_off;
	load_addr_t prog_idx;
	logic in_gfx;
	logic in_prog;
	bank_e dec_bank;

	logic byte_strobe;
	logic gfx_last;

	// Host bytes only count while a download runs
	assign byte_strobe = download && load_wr;

	// ######################################################################
	// Region decode
	// ######################################################################

	always_comb begin
		// Offsets wrap below the base, so one compare covers both ends
		gfx_off = load_addr - `GFX_BASE;
		prog_off = load_addr - `PROG_BASE;
		in_gfx = (gfx_off <= (`GFX_LIMIT - `GFX_BASE));
		in_prog = (prog_off < load_addr_t'(`NUM_PROG_BANKS * `PROG_BANK_BYTES));
		// Bank number from the offset
		prog_idx = prog_off / `PROG_BANK_BYTES;
		if (in_prog) begin
			dec_bank = bank_e'(prog_idx[$bits(bank_e)-1:0]);
		end else begin
			dec_bank = bank_none;
		end
	end

	// Byte history for word and dword assembly
	always_ff @(posedge clk_sys) begin
		if (byte_strobe) begin
			acc_bytes <= {acc_bytes[15:0], load_data};
		end
	end

	// Download phase, one register behind the host flag
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= load_idle;
		end else begin
			state <= download ? load_active : load_idle;
		end
	end

	assign gfx_wr.busy = (state == load_active);

	// ######################################################################
	// Program words
	// ######################################################################

	// Write goes out with the odd byte, even byte in the high half
	assign prog_wr.we = byte_strobe && in_prog && load_addr[0];
	assign prog_wr.bank = dec_bank;
	// Word address inside the bank
	assign prog_wr.addr = prog_off[`PROG_WORDS_LOG2:1];
	assign prog_wr.data = {acc_bytes[7:0], load_data};

	// ######################################################################
	// Graphics dwords
	// ######################################################################

	// Fourth byte of a dword
	assign gfx_last = byte_strobe && in_gfx && (load_addr[1:0] == 2'b11);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			gfx_wr.we <= 1'b0;
		end else begin
			gfx_wr.we <= gfx_last;
		end
	end

	// First byte lands most significant
	always_ff @(posedge clk_sys) begin
		if (gfx_last) begin
			gfx_wr.addr <= gfx_off[`GFX_WORDS_LOG2+1:2];
			gfx_wr.data <= {acc_bytes, load_data};
		end
	end

	// Registered dword write and the next odd program byte never meet
	// with bytes in ascending order
	assert property (@(posedge clk_sys) disable iff (rst) !(prog_wr.we && gfx_wr.we))
		else $error("program and graphics write in the same cycle");

endmodule

// ==== source/gfx_store.sv ====
// Single-port graphics store, loader and fetch arbiter, and fetch read pipeline
`timescale 1ns/1ps
`include "rom_system_settings.svh"

module gfx_store
	import rom_system_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst,
	gfx_wr_if.store   gfx_wr,
	input  logic      fetch_req,
	input  gfx_addr_t fetch_addr,
	output dword_t    fetch_data,
	output logic      fetch_valid
);

	localparam int lat = `FETCH_LATENCY;

	dword_t mem [2**`GFX_WORDS_LOG2];

	// Shared port
	gfx_addr_t port_addr;
	logic port_we;
	logic port_rd;

	// Stage 0 is the memory output, later stages are output registers
	dword_t data_pipe [lat];
	logic [lat-1:0] vld_pipe;

	// ######################################################################
	// Arbiter
	// ######################################################################

	// Loader owns the port for the whole download
	// Fetch port owns it otherwise
	always_comb begin
		if (gfx_wr.busy) begin
			port_addr = gfx_wr.addr;
			port_we = gfx_wr.we;
			port_rd = 1'b0;
		end else begin
			port_addr = fetch_addr;
			port_we = 1'b0;
			port_rd = fetch_req;
		end
	end

	// ######################################################################
	// Memory and read pipeline
	// ######################################################################

	always_ff @(posedge clk_sys) begin
		if (port_we) begin
			mem[port_addr] <= gfx_wr.data;
		end
		// Read old data on a write cycle
		data_pipe[0] <= mem[port_addr];
		for (int i = 1; i < lat; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	// Valid tags follow the data, flushed when the loader takes over
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vld_pipe <= '0;
		end else if (gfx_wr.busy) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= (vld_pipe << 1) | lat'(port_rd);
		end
	end

	assign fetch_data = data_pipe[lat-1];
	// Busy rising drops the read still in its last stage
	assign fetch_valid = vld_pipe[lat-1] & ~gfx_wr.busy;

	// Every valid answers a request exactly lat cycles back
	assert property (@(posedge clk_sys) disable iff (rst)
		fetch_valid |-> !gfx_wr.busy && $past(fetch_req, lat))
		else $error("fetch_valid without matching request or during download");

endmodule

// ==== source/prog_rom_bank.sv ====
// Five dual-port program ROM banks with the CPU read port and priority select mux
`timescale 1ns/1ps
`include "rom_system_settings.svh"

module prog_rom_bank
	import rom_system_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	rom_wr_if.banks    prog_wr,
	input  bank_sel_t  rom_sel_n,
	input  prog_addr_t cpu_addr,
	output word_t      cpu_data
);

	localparam int num_banks = `NUM_PROG_BANKS;

	// Registered read word of each bank
	word_t rd_q [num_banks];
	// Selects delayed to line up with the read data
	bank_sel_t sel_q;

	// ######################################################################
	// Bank arrays
	// ######################################################################

	for (genvar g = 0; g < num_banks; g++) begin : g_bank
		word_t mem [2**`PROG_WORDS_LOG2];
		logic wr_hit;

		// Bank index equals the enum encoding
		assign wr_hit = prog_wr.we && (prog_wr.bank == bank_e'(g));

		// Loader on the write port, CPU on the read port
		always_ff @(posedge clk_sys) begin
			if (wr_hit) begin
				mem[prog_wr.addr] <= prog_wr.data;
			end
			rd_q[g] <= mem[cpu_addr];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			// Nothing selected
			sel_q <= '1;
		end else begin
			sel_q <= rom_sel_n;
		end
	end

	// ######################################################################
	// Read mux
	// ######################################################################

	// Walk from slap down to rom0 so the lowest select wins
	// Zero when no select is low
	always_comb begin
		cpu_data = '0;
		for (int i = num_banks - 1; i >= 0; i--) begin
			if (!sel_q[i]) begin
				cpu_data = rd_q[i];
			end
		end
	end

	// Loader decode must keep writes inside the bank map
	assert property (@(posedge clk_sys) disable iff (rst)
		prog_wr.we |-> prog_wr.bank != bank_none)
		else $error("program write outside the bank map");

endmodule

// ==== source/player_inputs.sv ====
// Keyboard event decoder producing the joystick byte and the system switch byte
`timescale 1ns/1ps

module player_inputs
	import rom_system_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  key_event_t key_event,
	input  logic       service,
	output byte_t      joy_out,
	output sys_sw_t    sys_n
);

	// Set 2 scancodes, extended keys carry bit 8
	localparam logic [8:0] sc_up = 9'h175;
	localparam logic [8:0] sc_down = 9'h172;
	localparam logic [8:0] sc_left = 9'h16B;
	localparam logic [8:0] sc_right = 9'h174;
	localparam logic [8:0] sc_r = 9'h02D;
	localparam logic [8:0] sc_f = 9'h02B;
	localparam logic [8:0] sc_d = 9'h023;
	localparam logic [8:0] sc_g = 9'h034;
	localparam logic [8:0] sc_lctrl = 9'h014;
	localparam logic [8:0] sc_a = 9'h01C;
	localparam logic [8:0] sc_lalt = 9'h011;
	localparam logic [8:0] sc_s = 9'h01B;
	localparam logic [8:0] sc_5 = 9'h02E;
	localparam logic [8:0] sc_6 = 9'h036;
	localparam logic [8:0] sc_7 = 9'h03D;

	logic toggle_q;
	logic pressed;
	logic [8:0] scancode;

	// Latched buttons, active high
	logic start_1;
	logic start_2;
	logic jump_1;
	logic jump_2;
	logic coin_l;
	logic coin_r;
	logic coin_aux;

	assign pressed = key_event[9];
	assign scancode = key_event[8:0];

	// ######################################################################
	// Event decode
	// ######################################################################

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			// Track the toggle through reset, no event on release
			toggle_q <= key_event[10];
			joy_out <= '0;
			start_1 <= 1'b0;
			start_2 <= 1'b0;
			jump_1 <= 1'b0;
			jump_2 <= 1'b0;
			coin_l <= 1'b0;
			coin_r <= 1'b0;
			coin_aux <= 1'b0;
		end else begin
			toggle_q <= key_event[10];
			// New event on any toggle change
			if (key_event[10] != toggle_q) begin
				case (scancode)
					// Player 1 in the upper nibble
					sc_up: joy_out[7] <= pressed;
					sc_down: joy_out[6] <= pressed;
					sc_left: joy_out[5] <= pressed;
					sc_right: joy_out[4] <= pressed;
					// Player 2 in the lower nibble
					sc_r: joy_out[3] <= pressed;
					sc_f: joy_out[2] <= pressed;
					sc_d: joy_out[1] <= pressed;
					sc_g: joy_out[0] <= pressed;
					sc_lctrl: start_1 <= pressed;
					sc_a: start_2 <= pressed;
					sc_lalt: jump_1 <= pressed;
					sc_s: jump_2 <= pressed;
					sc_5: coin_l <= pressed;
					sc_6: coin_r <= pressed;
					sc_7: coin_aux <= pressed;
					default: ;
				endcase
			end
		end
	end

	// Service, aux coin, right coin, left coin, two unused, jump, start 2, start 1
	// Both players share one jump line
	assign sys_n = {~service, ~coin_aux, ~coin_r, ~coin_l, 2'b11,
		~(jump_1 | jump_2), ~start_2, ~start_1};

endmodule

// ==== source/rom_system_top.sv ====
// Top level of the ROM loading core with loader, graphics store, program banks and controls
`timescale 1ns/1ps

module rom_system_top
	import rom_system_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	// Host download stream
	input  logic       download,
	input  logic       load_wr,
	input  load_addr_t load_addr,
	input  byte_t      load_data,
	// Video fetch port
	input  logic       fetch_req,
	input  gfx_addr_t  fetch_addr,
	output dword_t     fetch_data,
	output logic       fetch_valid,
	// CPU program ROM port
	input  bank_sel_t  rom_sel_n,
	input  prog_addr_t cpu_addr,
	output word_t      cpu_data,
	// Controls
	input  key_event_t key_event,
	input  logic       service,
	output byte_t      joy_out,
	output sys_sw_t    sys_n
);

	rom_wr_if prog_wr ();
	gfx_wr_if gfx_wr ();

	// ######################################################################
	// Download path
	// ######################################################################

	rom_loader u_loader (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.download  (download),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.prog_wr   (prog_wr.loader),
		.gfx_wr    (gfx_wr.loader)
	);

	// Graphics dwords, shared with the fetch port
	gfx_store u_gfx_store (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.gfx_wr      (gfx_wr.store),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_data  (fetch_data),
		.fetch_valid (fetch_valid)
	);

	// Program words for the CPU
	prog_rom_bank u_prog_rom_bank (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.prog_wr   (prog_wr.banks),
		.rom_sel_n (rom_sel_n),
		.cpu_addr  (cpu_addr),
		.cpu_data  (cpu_data)
	);

	// Keyboard to player controls
	player_inputs u_player_inputs (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.key_event (key_event),
		.service   (service),
		.joy_out   (joy_out),
		.sys_n     (sys_n)
	);

endmodule

// ==== dv/tb_rom_system.sv ====
// Trace-driven testbench for the ROM loading core with per-test reporting
`timescale 1ns/1ps

module tb_rom_system
	import rom_system_pkg::*;
();

	localparam int clk_period = 8;
	// Cycles from driving fetch_req to fetch_valid
	localparam int fetch_latency = 2;
	// Cycles watched after a fetch for valid pulses
	localparam int fetch_window = 6;
	localparam int max_recs = 64;
	localparam int rec_words = 5;

	// Record opcodes, first word of a record
	localparam int op_end = 0;
	localparam int op_download = 1;
	localparam int op_load = 2;
	localparam int op_fetch = 3;
	localparam int op_fetch_pair = 4;
	localparam int op_cpu_read = 5;
	localparam int op_key = 6;

	logic clk_sys;
	logic rst;
	logic download;
	logic load_wr;
	load_addr_t load_addr;
	byte_t load_data;
	logic fetch_req;
	gfx_addr_t fetch_addr;
	dword_t fetch_data;
	logic fetch_valid;
	bank_sel_t rom_sel_n;
	prog_addr_t cpu_addr;
	word_t cpu_data;
	key_event_t key_event;
	logic service;
	byte_t joy_out;
	sys_sw_t sys_n;

	logic [31:0] trace [0:max_recs*rec_words-1];
	int num_recs = 0;
	int pass_count = 0;
	int fail_count = 0;
	logic key_toggle;
	// Valid pulses seen after the last fetch burst
	dword_t got_data [$];
	int got_cycle [$];

	rom_system_top u_dut (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.download    (download),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_data  (fetch_data),
		.fetch_valid (fetch_valid),
		.rom_sel_n   (rom_sel_n),
		.cpu_addr    (cpu_addr),
		.cpu_data    (cpu_data),
		.key_event   (key_event),
		.service     (service),
		.joy_out     (joy_out),
		.sys_n       (sys_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// Budget of 20 cycles per trace record, counted from reset release
	initial begin
		wait (rst === 1'b0 && num_recs > 0);
		repeat (num_recs * 20) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles with the trace unfinished", num_recs * 20);
		$display("Test failed");
		$finish;
	end

	// ##########################################################################
	// Stimulus tasks
	// ##########################################################################

	task automatic report_test(input string name, input int bad);
		if (bad == 0) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: FAILED with %0d errors", name, bad);
		end
	endtask

	task automatic set_download(input logic level);
		@(posedge clk_sys);
		#1;
		download = level;
	endtask

	// One host byte, strobe held for a single cycle
	task automatic load_byte(input load_addr_t addr, input byte_t data);
		@(posedge clk_sys);
		#1;
		load_wr = 1'b1;
		load_addr = addr;
		load_data = data;
		@(posedge clk_sys);
		#1;
		load_wr = 1'b0;
	endtask

	// Issue one or two requests on consecutive cycles and log every valid
	task automatic run_fetches(input int n, input gfx_addr_t a1, input gfx_addr_t a2);
		got_data.delete();
		got_cycle.delete();
		@(posedge clk_sys);
		#1;
		fetch_req = 1'b1;
		fetch_addr = a1;
		for (int c = 1; c <= fetch_window; c++) begin
			@(posedge clk_sys);
			#1;
			if (fetch_valid) begin
				got_data.push_back(fetch_data);
				got_cycle.push_back(c);
			end
			if (c < n) begin
				fetch_addr = a2;
			end else begin
				fetch_req = 1'b0;
			end
		end
	endtask

	task automatic single_fetch(input gfx_addr_t addr, input logic want_valid,
		input dword_t exp, output int bad);
		bad = 0;
		run_fetches(1, addr, addr);
		if (!want_valid) begin
			// Store belongs to the loader, request must be dropped
			if (got_data.size() != 0) begin
				$display("Fetch at dword %03h during download produced a fetch_valid pulse", addr);
				bad++;
			end
		end else if (got_data.size() == 0) begin
			$display("Fetch at dword %03h got no fetch_valid pulse within %0d cycles",
				addr, fetch_window);
			bad++;
		end else begin
			if (got_cycle[0] != fetch_latency) begin
				$display("Fail at %0d ns: fetch %03h valid after %0d cycles, expected %0d",
					$time, addr, got_cycle[0], fetch_latency);
				bad++;
			end
			if (got_data[0] !== exp) begin
				$display("Fail at %0d ns: fetch %03h returned %08h, expected %08h",
					$time, addr, got_data[0], exp);
				bad++;
			end
			if (got_data.size() > 1) begin
				$display("Fetch at dword %03h produced more than one fetch_valid pulse", addr);
				bad++;
			end
		end
	endtask

	// Back-to-back requests, answers expected in request order
	task automatic fetch_pair(input gfx_addr_t a1, input gfx_addr_t a2,
		input dword_t e1, input dword_t e2, output int bad);
		dword_t exp_q [2];
		exp_q[0] = e1;
		exp_q[1] = e2;
		bad = 0;
		run_fetches(2, a1, a2);
		if (got_data.size() != 2) begin
			$display("Fetches at %03h and %03h gave %0d valid pulses instead of 2",
				a1, a2, got_data.size());
			bad++;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (got_cycle[i] != fetch_latency + i) begin
					$display("Fail at %0d ns: pair answer %0d valid after %0d cycles",
						$time, i, got_cycle[i]);
					bad++;
				end
				if (got_data[i] !== exp_q[i]) begin
					$display("Fail at %0d ns: pair answer %0d was %08h, expected %08h",
						$time, i, got_data[i], exp_q[i]);
					bad++;
				end
			end
		end
	endtask

	// Word shows one cycle after select and address
	task automatic cpu_read(input bank_sel_t sel, input prog_addr_t addr,
		input word_t exp, output int bad);
		bad = 0;
		@(posedge clk_sys);
		#1;
		rom_sel_n = sel;
		cpu_addr = addr;
		@(posedge clk_sys);
		#1;
		if (cpu_data !== exp) begin
			$display("Fail at %0d ns: sel_n %05b addr %03h read %04h, expected %04h",
				$time, sel, addr, cpu_data, exp);
			bad++;
		end
		rom_sel_n = '1;
	endtask

	// Each event flips the toggle bit
	task automatic send_key(input logic pressed, input logic [8:0] code, input logic svc,
		input byte_t exp_joy, input sys_sw_t exp_sys, output int bad);
		bad = 0;
		@(posedge clk_sys);
		#1;
		key_toggle = ~key_toggle;
		key_event = {key_toggle, pressed, code};
		service = svc;
		@(posedge clk_sys);
		#1;
		if (joy_out !== exp_joy) begin
			$display("Fail at %0d ns: key %03h joy_out %02h, expected %02h",
				$time, code, joy_out, exp_joy);
			bad++;
		end
		if (sys_n !== exp_sys) begin
			$display("Fail at %0d ns: key %03h sys_n %03h, expected %03h",
				$time, code, sys_n, exp_sys);
			bad++;
		end
	endtask

	// ##########################################################################
	// Trace replay
	// ##########################################################################

	initial begin : main_seq
		int bad;
		logic [31:0] op;
		logic [31:0] fa;
		logic [31:0] fb;
		logic [31:0] fc;
		logic [31:0] fd;
		rst = 1'b1;
		download = 1'b0;
		load_wr = 1'b0;
		load_addr = '0;
		load_data = '0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		rom_sel_n = '1;
		cpu_addr = '0;
		key_toggle = 1'b0;
		key_event = '0;
		service = 1'b0;
		$readmemh("dv/rom_system_trace.txt", trace);
		// Records run up to the end opcode
		while (num_recs < max_recs && !$isunknown(trace[num_recs*rec_words])
			&& trace[num_recs*rec_words] != op_end) begin
			num_recs++;
		end
		if (num_recs == 0) begin
			$display("Trace file held no records");
			fail_count++;
		end
		repeat (3) @(posedge clk_sys);
		#1;
		rst = 1'b0;
		for (int rec = 0; rec < num_recs; rec++) begin
			op = trace[rec*rec_words];
			fa = trace[rec*rec_words+1];
			fb = trace[rec*rec_words+2];
			fc = trace[rec*rec_words+3];
			fd = trace[rec*rec_words+4];
			case (op)
				op_download: set_download(fa[0]);
				op_load: load_byte(fa[15:0], fb[7:0]);
				op_fetch: begin
					single_fetch(fa[11:0], fb[0], fc, bad);
					report_test($sformatf("Record %0d fetch %03h", rec, fa[11:0]), bad);
				end
				op_fetch_pair: begin
					fetch_pair(fa[11:0], fb[11:0], fc, fd, bad);
					report_test($sformatf("Record %0d fetch pair", rec), bad);
				end
				op_cpu_read: begin
					cpu_read(fa[4:0], fb[10:0], fc[15:0], bad);
					report_test($sformatf("Record %0d CPU read %03h", rec, fb[10:0]), bad);
				end
				op_key: begin
					send_key(fa[0], fb[8:0], fc[0], fd[19:12], fd[8:0], bad);
					report_test($sformatf("Record %0d key %03h", rec, fb[8:0]), bad);
				end
				default: begin
					$display("Trace record %0d holds unknown opcode %0h", rec, op);
					fail_count++;
				end
			endcase
		end
		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== dv/rom_system_trace.txt ====
// Columns: opcode, a, b, c, d. 1 download level, 2 load addr byte, 3 fetch addr want_valid dword
// 4 fetch pair addr1 addr2 dword1 dword2, 5 CPU read sel_n addr word, 6 key pressed code service joy_sys, 0 end
1 1 0 0 0
// Two graphics dwords at dword 4 and 5
2 0010 11 0 0
2 0011 22 0 0
2 0012 33 0 0
2 0013 44 0 0
2 0014 55 0 0
2 0015 66 0 0
2 0016 77 0 0
2 0017 88 0 0
// rom0 words 0 and 1, rom2 word 0, slap word 3
2 4000 AB 0 0
2 4001 CD 0 0
2 4002 12 0 0
2 4003 34 0 0
2 6000 99 0 0
2 6001 88 0 0
2 8006 5A 0 0
2 8007 A5 0 0
1 0 0 0 0
3 004 1 11223344 0
4 004 005 11223344 55667788
// Single banks, then rom0 over rom2, then nothing selected
5 1E 000 ABCD 0
5 1E 001 1234 0
5 0F 003 5AA5 0
5 1A 000 ABCD 0
5 1B 000 9988 0
5 1F 000 0000 0
// Fetch dropped while the loader owns the store
1 1 0 0 0
3 004 0 0 0
1 0 0 0 0
3 005 1 55667788 0
// Arrows, joy_out in the top byte, sys_n in the low bits
6 1 175 0 801FF
6 1 174 0 901FF
6 0 175 0 101FF
6 1 16B 0 301FF
6 1 172 0 701FF
6 0 172 0 301FF
6 0 16B 0 101FF
6 0 174 0 001FF
// R, left ctrl, S, coin 5
6 1 02D 0 081FF
6 0 02D 0 001FF
6 1 014 0 001FE
6 0 014 0 001FF
6 1 01B 0 001FB
6 0 01B 0 001FF
6 1 02E 0 001DF
6 0 02E 0 001FF
// G with service held
6 1 034 1 010FF
6 0 034 0 001FF
0 0 0 0 0

// ==== src.f ====
+incdir+include
source/rom_system_pkg.sv
source/load_ifs.sv
source/rom_loader.sv
source/gfx_store.sv
source/prog_rom_bank.sv
source/player_inputs.sv
source/rom_system_top.sv
dv/tb_rom_system.sv

// ==== Bender.yml ====
package:
  name: rom_system

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/rom_system_pkg.sv
      - source/load_ifs.sv
      - source/rom_loader.sv
      - source/gfx_store.sv
      - source/prog_rom_bank.sv
      - source/player_inputs.sv
      - source/rom_system_top.sv
  - target: test
    files:
      - dv/tb_rom_system.sv
